/* verilog/lc3b_consts.svh */
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// Fetch starts here after reset.
`define LC3B_RESET_PC 16'h0000

// Architectural register count.
`define LC3B_NUM_REGS 8

// BR with nzp of 000 never branches.
`define LC3B_NOP_WORD 16'h0000

// Instruction field positions.
`define LC3B_OPCODE_LSB 12
`define LC3B_DR_LSB 9
`define LC3B_SR1_LSB 6

// CC value after reset.
`define LC3B_CC_Z 3'b010

`endif

/* verilog/lc3b_types.sv */
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// Only part of the ISA is executed; the rest decodes as NOP.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_and  = 2'b01,
		alu_not  = 2'b10,
		alu_pass = 2'b11
	} alu_op;

	typedef enum logic [2:0] {
		mem_none = 3'b000,
		mem_ldr  = 3'b001,
		mem_str  = 3'b010,
		mem_ldb  = 3'b011,
		mem_stb  = 3'b100
	} mem_op;

endpackage : lc3b_types

`default_nettype wire

/* verilog/cpu_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module cpu_control (
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word id_instr,
	input lc3b_types::lc3b_reg ex_dest,
	input lc3b_types::lc3b_reg mem_dest,
	input lc3b_types::lc3b_reg wb_dest,
	input logic ex_writes,
	input logic mem_writes,
	input logic wb_writes,
	input logic branch_taken,
	input logic fetch_ready,
	input logic mem_ready,
	output logic advance,
	output logic stall_id,
	output logic flush,
	output lc3b_types::alu_op id_aluop,
	output lc3b_types::mem_op id_memop,
	output logic id_use_imm,
	output logic id_writes_reg,
	output logic id_sets_cc,
	output logic id_is_branch
);
	import lc3b_types::*;

	lc3b_opcode opcode;
	lc3b_reg src_a;
	lc3b_reg src_b;
	logic uses_a;
	logic uses_b;
	logic is_store;
	logic reg_hazard;
	logic cc_hazard;
	logic [2:0] cc_inflight; // Bit 0 is EX, bit 2 is WB.

	function automatic logic pending_write(input lc3b_reg src);
		pending_write = (ex_writes && ex_dest == src) ||
			(mem_writes && mem_dest == src) ||
			(wb_writes && wb_dest == src);
	endfunction

	assign opcode = lc3b_opcode'(id_instr[`LC3B_OPCODE_LSB +: 4]);
	assign src_a = id_instr[`LC3B_SR1_LSB +: 3];
	assign src_b = is_store ? id_instr[`LC3B_DR_LSB +: 3] : id_instr[2:0]; // Store data reg.

	always_comb begin
		id_aluop = alu_pass;
		id_memop = mem_none;
		id_use_imm = 1'b0;
		id_writes_reg = 1'b0;
		id_is_branch = 1'b0;
		uses_a = 1'b0;
		uses_b = 1'b0;
		is_store = 1'b0;
		case (opcode)
			op_add, op_and: begin
				id_aluop = (opcode == op_add) ? alu_add : alu_and;
				id_use_imm = id_instr[5]; // imm5 form.
				id_writes_reg = 1'b1;
				uses_a = 1'b1;
				uses_b = !id_instr[5];
			end
			op_not: begin
				id_aluop = alu_not;
				id_writes_reg = 1'b1;
				uses_a = 1'b1;
			end
			op_ldr, op_ldb: begin
				id_aluop = alu_add; // Base plus offset.
				id_memop = (opcode == op_ldr) ? mem_ldr : mem_ldb;
				id_use_imm = 1'b1;
				id_writes_reg = 1'b1;
				uses_a = 1'b1;
			end
			op_str, op_stb: begin
				id_aluop = alu_add;
				id_memop = (opcode == op_str) ? mem_str : mem_stb;
				id_use_imm = 1'b1;
				uses_a = 1'b1;
				uses_b = 1'b1;
				is_store = 1'b1;
			end
			op_br: id_is_branch = 1'b1;
			default: id_is_branch = 1'b0; // Unsupported, runs as NOP.
		endcase
	end

	assign id_sets_cc = id_writes_reg; // All writers here set CC.

	always_comb begin
		reg_hazard = (uses_a && pending_write(src_a)) || (uses_b && pending_write(src_b));
		cc_hazard = id_is_branch && (id_instr[`LC3B_DR_LSB +: 3] != 3'b000) && (|cc_inflight);
	end

	assign advance = fetch_ready & mem_ready; // Whole pipe moves together.
	assign flush = advance & branch_taken;
	assign stall_id = (reg_hazard | cc_hazard) & !flush; // Flushed ID needs no stall.

	// Tracks CC writers between EX and WB.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cc_inflight <= 3'b000;
		else if (advance)
			cc_inflight <= {cc_inflight[1:0], id_sets_cc & !stall_id & !flush};
	end

endmodule : cpu_control

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module fetch_unit (
	input logic clk,
	input logic rst_n,
	input logic advance,
	input logic stall_id,
	input logic flush,
	input lc3b_types::lc3b_word branch_target,
	input lc3b_types::lc3b_word instr,
	input logic instruction_response,
	output lc3b_types::lc3b_word instruction_address,
	output logic instruction_request,
	output logic fetch_ready,
	output lc3b_types::lc3b_word id_instr,
	output lc3b_types::lc3b_word id_pc
);
	import lc3b_types::*;

	lc3b_word pc;
	lc3b_word fetch_buf;
	lc3b_word fetch_word;
	logic req_q;
	logic fetched; // Word in hand, waiting for advance.

	assign instruction_address = pc;
	assign instruction_request = req_q;
	assign fetch_ready = fetched | (req_q & instruction_response);
	assign fetch_word = fetched ? fetch_buf : instr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `LC3B_RESET_PC;
			req_q <= 1'b0;
			fetched <= 1'b0;
		end else if (advance && !stall_id) begin
			pc <= flush ? branch_target : pc + 16'd2;
			req_q <= 1'b1; // Next access starts right away.
			fetched <= 1'b0;
		end else if (advance || (req_q && instruction_response)) begin
			req_q <= 1'b0; // Keep the word while ID stalls.
			fetched <= 1'b1;
		end else if (!fetched) begin
			req_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req_q && instruction_response)
			fetch_buf <= instr;
	end

	// IF/ID register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_instr <= `LC3B_NOP_WORD;
			id_pc <= `LC3B_RESET_PC;
		end else if (advance) begin
			if (flush) begin
				id_instr <= `LC3B_NOP_WORD;
			end else if (!stall_id) begin
				id_instr <= fetch_word;
				id_pc <= pc;
			end
		end
	end

endmodule : fetch_unit

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module regfile (
	input logic clk,
	input logic rst_n,
	input logic load,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word regs [`LC3B_NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// No bypass, a same-cycle write is seen next cycle.
	assign reg_a = regs[src_a];
	assign reg_b = regs[src_b];

endmodule : regfile

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
	input lc3b_types::alu_op aluop,
	input logic use_imm,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	input lc3b_types::lc3b_word imm,
	output lc3b_types::lc3b_word f
);
	import lc3b_types::*;

	lc3b_word operand;

	// imm is already sign-extended and scaled.
	assign operand = use_imm ? imm : b;

	always_comb begin
		case (aluop)
			alu_add: f = a + operand; // Also address generation.
			alu_and: f = a & operand;
			alu_not: f = ~a;
			default: f = a; // Pass-through.
		endcase
	end

endmodule : alu

`default_nettype wire

/* verilog/mem_access.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_access (
	input logic clk,
	input logic rst_n,
	input logic advance,
	input lc3b_types::mem_op memop,
	input lc3b_types::lc3b_word addr,
	input lc3b_types::lc3b_word store_data,
	input lc3b_types::lc3b_word mem_rdata,
	input logic data_response,
	output logic data_request,
	output logic write_enable,
	output lc3b_types::lc3b_word mem_address,
	output logic [1:0] mem_byte_enable,
	output lc3b_types::lc3b_word write_data,
	output logic mem_ready,
	output lc3b_types::lc3b_word load_data
);
	import lc3b_types::*;

	typedef enum logic [1:0] {
		ms_idle,
		ms_req,
		ms_done
	} mem_state;

	mem_state state;
	lc3b_word mar;
	lc3b_word mdr; // Store data out, load data back.
	logic is_store;
	logic is_byte;
	logic lane_hi;
	logic start;
	logic [7:0] load_byte;

	assign start = (state == ms_idle) && (memop != mem_none);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ms_idle;
		end else begin
			case (state)
				ms_idle:
					if (start)
						state <= ms_req;
				ms_req:
					if (data_response)
						state <= ms_done;
				default:
					if (advance)
						state <= ms_idle; // Done until the pipe moves.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mar <= {addr[15:1], 1'b0};
			is_store <= (memop == mem_str) || (memop == mem_stb);
			is_byte <= (memop == mem_ldb) || (memop == mem_stb);
			lane_hi <= addr[0];
			mdr <= (memop == mem_stb) ? {2{store_data[7:0]}} : store_data;
		end else if (state == ms_req && data_response && !is_store) begin
			mdr <= mem_rdata;
		end
	end

	assign data_request = (state == ms_req);
	assign write_enable = data_request && is_store;
	assign mem_address = mar;
	assign write_data = mdr;
	assign mem_byte_enable = !is_byte ? 2'b11 : (lane_hi ? 2'b10 : 2'b01);
	assign mem_ready = (state == ms_done) || (state == ms_idle && memop == mem_none);

	assign load_byte = lane_hi ? mdr[15:8] : mdr[7:0];
	assign load_data = is_byte ? {8'h00, load_byte} : mdr; // LDB zero-extends.

endmodule : mem_access

`default_nettype wire

/* verilog/cpu_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module cpu_datapath (
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word instr,
	input logic instruction_response,
	input lc3b_types::lc3b_word mem_rdata,
	input logic data_response,
	output lc3b_types::lc3b_word instruction_address,
	output logic instruction_request,
	output lc3b_types::lc3b_word mem_address,
	output lc3b_types::lc3b_word write_data,
	output logic [1:0] mem_byte_enable,
	output logic data_request,
	output logic write_enable
);
	import lc3b_types::*;

	logic advance, stall_id, flush, fetch_ready, mem_ready, branch_taken;
	alu_op id_aluop, ex_aluop;
	mem_op id_memop, ex_memop, mem_memop;
	logic id_use_imm, id_writes_reg, id_sets_cc, id_is_branch;
	lc3b_word id_instr, id_pc, id_a, id_b, id_imm, id_br_ofs;
	lc3b_reg id_src_b;
	lc3b_word ex_pc, ex_a, ex_b, ex_imm, ex_br_ofs, ex_alu, branch_target;
	lc3b_reg ex_dest, mem_dest, wb_dest;
	lc3b_nzp ex_nzp, cc, wb_nzp;
	logic ex_use_imm, ex_writes, ex_sets_cc, ex_is_branch;
	lc3b_word mem_alu, mem_store, load_data, wb_value;
	logic mem_writes, mem_sets_cc, wb_writes, wb_sets_cc;

	cpu_control control (
		.clk, .rst_n, .id_instr, .ex_dest, .mem_dest, .wb_dest,
		.ex_writes, .mem_writes, .wb_writes, .branch_taken, .fetch_ready, .mem_ready,
		.advance, .stall_id, .flush, .id_aluop, .id_memop,
		.id_use_imm, .id_writes_reg, .id_sets_cc, .id_is_branch
	);

	fetch_unit fetch (
		.clk, .rst_n, .advance, .stall_id, .flush, .branch_target,
		.instr, .instruction_response, .instruction_address, .instruction_request,
		.fetch_ready, .id_instr, .id_pc
	);

	// ID: register read and immediate extension.
	assign id_src_b = (id_memop == mem_str || id_memop == mem_stb) ?
		id_instr[`LC3B_DR_LSB +: 3] : id_instr[2:0];

	regfile regs (
		.clk, .rst_n, .load(advance & wb_writes), .src_a(id_instr[`LC3B_SR1_LSB +: 3]),
		.src_b(id_src_b), .dest(wb_dest), .in(wb_value), .reg_a(id_a), .reg_b(id_b)
	);

	always_comb begin
		case (id_memop)
			mem_ldr, mem_str: id_imm = {{9{id_instr[5]}}, id_instr[5:0], 1'b0}; // Word offset.
			mem_ldb, mem_stb: id_imm = {{10{id_instr[5]}}, id_instr[5:0]};
			default: id_imm = {{11{id_instr[4]}}, id_instr[4:0]}; // imm5.
		endcase
	end
	assign id_br_ofs = {{6{id_instr[8]}}, id_instr[8:0], 1'b0};

	// ID/EX, stall or flush inserts a bubble.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{ex_writes, ex_sets_cc, ex_is_branch} <= 3'b000;
			ex_memop <= mem_none;
		end else if (advance) begin
			ex_writes <= id_writes_reg & !stall_id & !flush;
			ex_sets_cc <= id_sets_cc & !stall_id & !flush;
			ex_is_branch <= id_is_branch & !stall_id & !flush;
			ex_memop <= (stall_id || flush) ? mem_none : id_memop;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_pc <= id_pc;
			ex_a <= id_a;
			ex_b <= id_b;
			ex_imm <= id_imm;
			ex_br_ofs <= id_br_ofs;
			ex_dest <= id_instr[`LC3B_DR_LSB +: 3];
			ex_nzp <= id_instr[`LC3B_DR_LSB +: 3];
			ex_aluop <= id_aluop;
			ex_use_imm <= id_use_imm;
		end
	end

	// EX: ALU and branch resolution.
	alu ex_alu_unit (
		.aluop(ex_aluop), .use_imm(ex_use_imm), .a(ex_a), .b(ex_b), .imm(ex_imm), .f(ex_alu)
	);

	assign branch_target = ex_pc + 16'd2 + ex_br_ofs;
	assign branch_taken = ex_is_branch && |(ex_nzp & cc);

	// EX/MEM.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{mem_writes, mem_sets_cc} <= 2'b00;
			mem_memop <= mem_none;
		end else if (advance) begin
			{mem_writes, mem_sets_cc} <= {ex_writes, ex_sets_cc};
			mem_memop <= ex_memop;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			mem_alu <= ex_alu;
			mem_store <= ex_b;
			mem_dest <= ex_dest;
		end
	end

	mem_access dmem (
		.clk, .rst_n, .advance, .memop(mem_memop), .addr(mem_alu), .store_data(mem_store),
		.mem_rdata, .data_response, .data_request, .write_enable, .mem_address,
		.mem_byte_enable, .write_data, .mem_ready, .load_data
	);

	// MEM/WB.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			{wb_writes, wb_sets_cc} <= 2'b00;
		else if (advance)
			{wb_writes, wb_sets_cc} <= {mem_writes, mem_sets_cc};
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_value <= (mem_memop == mem_ldr || mem_memop == mem_ldb) ? load_data : mem_alu;
			wb_dest <= mem_dest;
		end
	end

	// WB: CC from the value being written.
	assign wb_nzp = wb_value[15] ? 3'b100 : ((wb_value == 16'h0000) ? 3'b010 : 3'b001);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cc <= `LC3B_CC_Z;
		else if (advance && wb_sets_cc)
			cc <= wb_nzp;
	end

endmodule : cpu_datapath

`default_nettype wire

/* dv/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module cpu_tb;
	import lc3b_types::*;

	localparam int NUM_TESTS = 9;
	localparam int PROG_WORDS = 16;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * PROG_WORDS * 20;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	lc3b_word instr = `LC3B_NOP_WORD;
	logic instruction_response = 1'b0;
	lc3b_word mem_rdata = 16'h0000;
	logic data_response = 1'b0;
	lc3b_word instruction_address;
	lc3b_word mem_address;
	lc3b_word write_data;
	logic instruction_request;
	logic data_request;
	logic write_enable;
	logic [1:0] mem_byte_enable;

	string name_tab [NUM_TESTS];
	lc3b_word prog_tab [NUM_TESTS][PROG_WORDS];
	lc3b_word exp_addr [NUM_TESTS];
	lc3b_word exp_data [NUM_TESTS];
	logic [1:0] exp_be [NUM_TESTS];

	int cur_test = 0;
	int i_wait = 0; // Cycles until the instruction response.
	int d_wait = 0;
	logic in_reset;
	logic store_seen = 1'b0;
	lc3b_word st_addr;
	lc3b_word st_data;
	logic [1:0] st_be;
	int error_count = 0;
	int reset_errors = 0;
	int failed_tests = 0;
	int errors_before;
	int cycle_count = 0;

	cpu_datapath dut (.*);

	always #4 clk = ~clk;

	function automatic lc3b_word enc_reg(input lc3b_opcode op, input int dr, input int sr1,
		input int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic lc3b_word enc_imm(input lc3b_opcode op, input int dr, input int sr1,
		input int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word enc_not(input int dr, input int sr);
		return {op_not, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	function automatic lc3b_word enc_mem(input lc3b_opcode op, input int r, input int base,
		input int ofs);
		return {op, r[2:0], base[2:0], ofs[5:0]}; // Offset6 in memory units.
	endfunction

	function automatic lc3b_word enc_br(input logic [2:0] nzp, input int ofs);
		return {op_br, nzp, ofs[8:0]};
	endfunction

	// Data memory pattern over all address bits.
	function automatic lc3b_word data_pattern(input lc3b_word a);
		return {a[7:0] ^ 8'hC3, a[15:8] ^ 8'h5A} + a;
	endfunction

	function automatic lc3b_word program_word(input lc3b_word a);
		return (a < 16'd32) ? prog_tab[cur_test][a[4:1]] : `LC3B_NOP_WORD;
	endfunction

	task automatic set_expect(input int t, input string name, input lc3b_word addr,
		input lc3b_word data, input logic [1:0] be);
		name_tab[t] = name;
		exp_addr[t] = addr;
		exp_data[t] = data;
		exp_be[t] = be;
	endtask

	task automatic build_table();
		for (int t = 0; t < NUM_TESTS; t++)
			for (int w = 0; w < PROG_WORDS; w++)
				prog_tab[t][w] = `LC3B_NOP_WORD;
		prog_tab[0][0] = enc_imm(op_add, 1, 0, 7); // R1 = 7.
		prog_tab[0][1] = enc_imm(op_add, 2, 1, 12); // Needs R1.
		prog_tab[0][2] = enc_imm(op_and, 3, 2, -2);
		prog_tab[0][3] = enc_mem(op_str, 3, 0, 4);
		set_expect(0, "add_and_imm", 16'd8, (16'd7 + 16'd12) & 16'hFFFE, 2'b11);
		prog_tab[1][0] = enc_imm(op_add, 1, 0, 9);
		prog_tab[1][1] = enc_imm(op_add, 2, 0, -6);
		prog_tab[1][2] = enc_reg(op_add, 3, 1, 2); // R3 = 3.
		prog_tab[1][3] = enc_reg(op_and, 4, 3, 1);
		prog_tab[1][4] = enc_reg(op_add, 4, 4, 3);
		prog_tab[1][5] = enc_mem(op_str, 4, 0, 5);
		set_expect(1, "add_and_reg", 16'd10,
			((16'd9 + 16'hFFFA) & 16'd9) + (16'd9 + 16'hFFFA), 2'b11);
		prog_tab[2][0] = enc_imm(op_add, 1, 0, 10);
		prog_tab[2][1] = enc_not(2, 1);
		prog_tab[2][2] = enc_imm(op_add, 5, 0, 6); // Base register.
		prog_tab[2][3] = enc_mem(op_str, 2, 5, 3);
		set_expect(2, "not_str", 16'd6 + (16'd3 << 1), ~16'd10, 2'b11);
		prog_tab[3][0] = enc_imm(op_add, 1, 0, 8);
		prog_tab[3][1] = enc_mem(op_ldr, 2, 1, 4); // Loads from 0x10.
		prog_tab[3][2] = enc_imm(op_add, 2, 2, 5);
		prog_tab[3][3] = enc_mem(op_str, 2, 1, -1);
		set_expect(3, "ldr_add_str", 16'd8 - 16'd2, data_pattern(16'd8 + 16'd8) + 16'd5, 2'b11);
		prog_tab[4][0] = enc_imm(op_add, 1, 0, 9);
		prog_tab[4][1] = enc_imm(op_add, 2, 0, -11); // Low byte F5.
		prog_tab[4][2] = enc_mem(op_stb, 2, 1, 4);
		set_expect(4, "stb_odd", 16'd12, 16'hF5F5, 2'b10); // Byte 13 is the high lane.
		prog_tab[5][0] = enc_imm(op_add, 1, 0, 6);
		prog_tab[5][1] = enc_imm(op_add, 2, 0, 13);
		prog_tab[5][2] = enc_mem(op_stb, 2, 1, 2);
		set_expect(5, "stb_even", 16'd8, 16'h0D0D, 2'b01);
		prog_tab[6][0] = enc_imm(op_add, 1, 0, 7);
		prog_tab[6][1] = enc_mem(op_ldb, 2, 1, 14); // Byte 21.
		prog_tab[6][2] = enc_mem(op_str, 2, 0, 1);
		set_expect(6, "ldb_odd", 16'd2, data_pattern(16'd20) >> 8, 2'b11);
		prog_tab[7][0] = enc_imm(op_add, 1, 0, -4);
		prog_tab[7][1] = enc_br(3'b100, 2); // Taken over two stores.
		prog_tab[7][2] = enc_mem(op_str, 1, 0, 2);
		prog_tab[7][3] = enc_mem(op_str, 1, 0, 3);
		prog_tab[7][4] = enc_mem(op_str, 1, 0, 4);
		set_expect(7, "br_taken", 16'd8, 16'hFFFC, 2'b11);
		prog_tab[8][0] = enc_imm(op_add, 1, 0, 5);
		prog_tab[8][1] = enc_br(3'b010, 1); // Result is positive.
		prog_tab[8][2] = enc_mem(op_str, 1, 0, 2);
		prog_tab[8][3] = enc_mem(op_str, 1, 0, 3);
		set_expect(8, "br_not_taken", 16'd4, 16'd5, 2'b11);
	endtask

	task automatic check_word(input string test, input string field, input lc3b_word expected,
		input lc3b_word actual);
		if (actual !== expected) begin
			$display("ERROR %s: %s expected %h actual %h", test, field, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_be(input string test, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: byte enable expected %b actual %b", test, expected, actual);
			error_count++;
		end
	endtask

	// Response comes 1 to 3 cycles after the request is seen.
	task automatic serve_instr();
		if (instruction_response) begin
			instruction_response = 1'b0; // Access done at this edge.
			if (instruction_request)
				i_wait = $urandom_range(3, 1);
		end else if (i_wait != 0) begin
			i_wait--;
			if (i_wait == 0) begin
				instr = program_word(instruction_address);
				instruction_response = 1'b1;
			end
		end else if (instruction_request) begin
			i_wait = $urandom_range(3, 1);
		end
	endtask

	task automatic serve_data();
		if (data_response) begin
			data_response = 1'b0;
			if (data_request)
				d_wait = $urandom_range(3, 1);
		end else if (d_wait != 0) begin
			d_wait--;
			if (d_wait == 0) begin
				if (write_enable && !store_seen) begin
					st_addr = mem_address;
					st_data = write_data;
					st_be = mem_byte_enable;
					store_seen = 1'b1; // First store only.
				end
				mem_rdata = data_pattern(mem_address);
				data_response = 1'b1;
			end
		end else if (data_request) begin
			d_wait = $urandom_range(3, 1);
		end
	endtask

	// Both memory models run here in a fixed order.
	always @(posedge clk) begin
		in_reset = !rst_n;
		if (in_reset && (data_request || write_enable)) begin
			$display("Data port active while rst_n is low at %0t.", $time);
			reset_errors++;
		end
		#1;
		if (in_reset) begin
			instruction_response = 1'b0;
			data_response = 1'b0;
			i_wait = 0;
			d_wait = 0;
			store_seen = 1'b0;
		end else begin
			serve_instr();
			serve_data();
		end
	end

	task automatic apply_reset(input int t);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		cur_test = t; // Instruction memory switches program.
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run reached %0d cycles while test %s waited for a store.",
			TIMEOUT_CYCLES, name_tab[cur_test]);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(48125));
		build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			apply_reset(t);
			while (!store_seen)
				@(posedge clk);
			errors_before = error_count;
			check_word(name_tab[t], "address", exp_addr[t], st_addr);
			check_word(name_tab[t], "data", exp_data[t], st_data);
			check_be(name_tab[t], exp_be[t], st_be);
			if (error_count == errors_before) begin
				$display("PASS %s", name_tab[t]);
			end else begin
				$display("FAIL %s", name_tab[t]);
				failed_tests++;
			end
		end
		$display("Tests run %0d, failed %0d, value errors %0d, reset errors %0d",
			NUM_TESTS, failed_tests, error_count, reset_errors);
		if (error_count == 0 && reset_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule : cpu_tb

`default_nettype wire

/* lc3b_lite.f */
+incdir+verilog
verilog/lc3b_types.sv
verilog/cpu_control.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/alu.sv
verilog/mem_access.sv
verilog/cpu_datapath.sv
dv/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cpu_tb -Mdir obj_dir -f lc3b_lite.f \
	&& ./obj_dir/Vcpu_tb | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
